// File: hdl/ahbBus_config.svh
`ifndef AHB_BUS_CONFIG_SVH
`define AHB_BUS_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define AHB_ADDR_W   32
`define AHB_DATA_W   32
`define AHB_SIZE_W   3
`define AHB_BURST_W  3
`define AHB_PROT_W   4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top nibble of hAddr picks the slave
`define AHB_MAP_HI   31
`define AHB_MAP_LO   28
`define SLAVE0_BASE  4'h0
`define SLAVE1_BASE  4'h1

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sram slaves
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SRAM_WORDS   256
// word index starts above the byte offset
`define SRAM_IDX_LO  2
`define SRAM0_WAIT   0
`define SRAM1_WAIT   2

`endif

// File: hdl/ahbBusPkg.sv
package ahbBusPkg;

	// htrans encodings
	typedef enum logic [1:0] {
		transIdle   = 2'b00,
		transBusy   = 2'b01,
		transNonSeq = 2'b10,
		transSeq    = 2'b11
	} transKind;

	// bus owner, masterNone is the idle default master
	typedef enum logic [1:0] {
		masterNone = 2'd0,
		master1    = 2'd1,
		master2    = 2'd2
	} masterId;

	// data-phase slave
	typedef enum logic [1:0] {
		selSram0   = 2'd0,
		selSram1   = 2'd1,
		selDefault = 2'd2
	} slaveSel;

endpackage

// File: hdl/ahbArbiter.sv
module ahbArbiter (
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                hBusReqM1,
	input  logic                hBusReqM2,
	input  logic                hReady,
	output logic                hGrantM1,
	output logic                hGrantM2,
	output ahbBusPkg::masterId  hMaster
);

	ahbBusPkg::masterId grantOwner;
	ahbBusPkg::masterId lastOwner;
	ahbBusPkg::masterId nextOwner;
	logic               holderReq;

	// does the current grant holder still want the bus
	always_comb begin
		case (grantOwner)
			ahbBusPkg::master1: holderReq = hBusReqM1;
			ahbBusPkg::master2: holderReq = hBusReqM2;
			default:            holderReq = 1'b0;
		endcase
	end

	// round robin, the last owner loses a tie
	always_comb begin
		if (holderReq) begin
			nextOwner = grantOwner;
		end else if (hBusReqM1 && hBusReqM2) begin
			if (lastOwner == ahbBusPkg::master1) begin
				nextOwner = ahbBusPkg::master2;
			end else begin
				nextOwner = ahbBusPkg::master1;
			end
		end else if (hBusReqM1) begin
			nextOwner = ahbBusPkg::master1;
		end else if (hBusReqM2) begin
			nextOwner = ahbBusPkg::master2;
		end else begin
			nextOwner = ahbBusPkg::masterNone;
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			grantOwner <= ahbBusPkg::masterNone;
			lastOwner  <= ahbBusPkg::master2;
		end else begin
			grantOwner <= nextOwner;
			if (grantOwner != ahbBusPkg::masterNone) begin
				lastOwner <= grantOwner;
			end
		end
	end

	// ownership of the address phase moves only when the previous transfer completes
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			hMaster <= ahbBusPkg::masterNone;
		end else if (hReady) begin
			hMaster <= grantOwner;
		end
	end

	assign hGrantM1 = (grantOwner == ahbBusPkg::master1);
	assign hGrantM2 = (grantOwner == ahbBusPkg::master2);

endmodule

// File: hdl/ahbMuxM2S.sv
`include "ahbBus_config.svh"

module ahbMuxM2S (
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  ahbBusPkg::masterId        hMaster,
	input  logic                      hReady,

	input  ahbBusPkg::transKind       hTransM1,
	input  ahbBusPkg::transKind       hTransM2,
	input  logic                      hWriteM1,
	input  logic                      hWriteM2,
	input  logic [`AHB_SIZE_W-1:0]    hSizeM1,
	input  logic [`AHB_SIZE_W-1:0]    hSizeM2,
	input  logic [`AHB_BURST_W-1:0]   hBurstM1,
	input  logic [`AHB_BURST_W-1:0]   hBurstM2,
	input  logic [`AHB_PROT_W-1:0]    hProtM1,
	input  logic [`AHB_PROT_W-1:0]    hProtM2,
	input  logic [`AHB_ADDR_W-1:0]    hAddrM1,
	input  logic [`AHB_ADDR_W-1:0]    hAddrM2,
	input  logic [`AHB_DATA_W-1:0]    hWDataM1,
	input  logic [`AHB_DATA_W-1:0]    hWDataM2,

	output ahbBusPkg::transKind       hTrans,
	output logic                      hWrite,
	output logic [`AHB_SIZE_W-1:0]    hSize,
	output logic [`AHB_BURST_W-1:0]   hBurst,
	output logic [`AHB_PROT_W-1:0]    hProt,
	output logic [`AHB_ADDR_W-1:0]    hAddr,
	output logic [`AHB_DATA_W-1:0]    hWData
);

	ahbBusPkg::masterId dataMaster;

	// owner of the data phase, one accepted transfer behind hMaster
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			dataMaster <= ahbBusPkg::masterNone;
		end else if (hReady) begin
			dataMaster <= hMaster;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address phase
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (hMaster)
			ahbBusPkg::master1: begin
				hTrans = hTransM1;
				hWrite = hWriteM1;
				hSize  = hSizeM1;
				hBurst = hBurstM1;
				hProt  = hProtM1;
				hAddr  = hAddrM1;
			end
			ahbBusPkg::master2: begin
				hTrans = hTransM2;
				hWrite = hWriteM2;
				hSize  = hSizeM2;
				hBurst = hBurstM2;
				hProt  = hProtM2;
				hAddr  = hAddrM2;
			end
			default: begin
				// default master parks the bus on IDLE
				hTrans = ahbBusPkg::transIdle;
				hWrite = 1'b0;
				hSize  = '0;
				hBurst = '0;
				hProt  = '0;
				hAddr  = '1;
			end
		endcase
	end

	// data phase
	always_comb begin
		case (dataMaster)
			ahbBusPkg::master1: hWData = hWDataM1;
			ahbBusPkg::master2: hWData = hWDataM2;
			default:            hWData = '0;
		endcase
	end

endmodule

// File: hdl/ahbDecoder.sv
`include "ahbBus_config.svh"

module ahbDecoder (
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic [`AHB_ADDR_W-1:0]  hAddr,
	input  ahbBusPkg::transKind     hTrans,
	input  logic                    hReady,
	output logic                    hSel0,
	output logic                    hSel1,
	output ahbBusPkg::slaveSel      dataSel,
	output logic                    hReadyOutDef,
	output logic                    hRespDef
);

	logic [`AHB_MAP_HI-`AHB_MAP_LO:0] region;
	ahbBusPkg::slaveSel               addrSel;
	logic                             active;
	logic                             errFirst;
	logic                             errLast;

	assign region = hAddr[`AHB_MAP_HI:`AHB_MAP_LO];
	assign active = (hTrans == ahbBusPkg::transNonSeq) || (hTrans == ahbBusPkg::transSeq);

	always_comb begin
		case (region)
			`SLAVE0_BASE: addrSel = ahbBusPkg::selSram0;
			`SLAVE1_BASE: addrSel = ahbBusPkg::selSram1;
			default:      addrSel = ahbBusPkg::selDefault;
		endcase
	end

	assign hSel0 = (addrSel == ahbBusPkg::selSram0);
	assign hSel1 = (addrSel == ahbBusPkg::selSram1);

	// default slave: wait cycle with ERROR, then ready cycle with ERROR
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			dataSel  <= ahbBusPkg::selSram0;
			errFirst <= 1'b0;
			errLast  <= 1'b0;
		end else begin
			if (hReady) begin
				dataSel <= addrSel;
			end
			errFirst <= hReady && active && (addrSel == ahbBusPkg::selDefault);
			errLast  <= errFirst;
		end
	end

	assign hReadyOutDef = !errFirst;
	assign hRespDef     = errFirst || errLast;

endmodule

// File: hdl/ahbMuxS2M.sv
`include "ahbBus_config.svh"

module ahbMuxS2M (
	input  ahbBusPkg::slaveSel       dataSel,
	input  logic [`AHB_DATA_W-1:0]   hRData0,
	input  logic [`AHB_DATA_W-1:0]   hRData1,
	input  logic                     hReadyOut0,
	input  logic                     hReadyOut1,
	input  logic                     hReadyOutDef,
	input  logic                     hResp0,
	input  logic                     hResp1,
	input  logic                     hRespDef,
	output logic [`AHB_DATA_W-1:0]   hRData,
	output logic                     hReady,
	output logic                     hResp
);

	// response of whichever slave owns the data phase
	always_comb begin
		case (dataSel)
			ahbBusPkg::selSram0: begin
				hRData = hRData0;
				hReady = hReadyOut0;
				hResp  = hResp0;
			end
			ahbBusPkg::selSram1: begin
				hRData = hRData1;
				hReady = hReadyOut1;
				hResp  = hResp1;
			end
			default: begin
				// default slave has no read data
				hRData = '0;
				hReady = hReadyOutDef;
				hResp  = hRespDef;
			end
		endcase
	end

endmodule

// File: hdl/ahbSramSlave.sv
`include "ahbBus_config.svh"

module ahbSramSlave #(
	parameter int waitStates = 0
) (
	input  logic                     HCLK,
	input  logic                     HRESETn,
	input  logic                     hSel,
	input  ahbBusPkg::transKind      hTrans,
	input  logic                     hWrite,
	input  logic [`AHB_SIZE_W-1:0]   hSize,
	input  logic [`AHB_ADDR_W-1:0]   hAddr,
	input  logic [`AHB_DATA_W-1:0]   hWData,
	input  logic                     hReady,
	output logic [`AHB_DATA_W-1:0]   hRData,
	output logic                     hReadyOut,
	output logic                     hResp
);

	localparam int idxW = $clog2(`SRAM_WORDS);
	localparam int cntW = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

	logic [`AHB_DATA_W-1:0] mem [`SRAM_WORDS];

	logic            accept;
	logic            active;
	logic            lastCycle;
	logic [cntW-1:0] waitCnt;
	logic            wrQ;
	logic [idxW-1:0] idxQ;

	// word accesses only, hSize passes through unchecked
	assign accept = hSel && hReady &&
		((hTrans == ahbBusPkg::transNonSeq) || (hTrans == ahbBusPkg::transSeq));

	assign lastCycle = (waitCnt == cntW'(waitStates));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data phase control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			active  <= 1'b0;
			waitCnt <= '0;
		end else if (hReady) begin
			active  <= accept;
			waitCnt <= '0;
		end else if (active && !lastCycle) begin
			waitCnt <= waitCnt + 1'b1;
		end
	end

	// address phase capture
	always_ff @(posedge HCLK) begin
		if (accept) begin
			wrQ  <= hWrite;
			idxQ <= hAddr[`SRAM_IDX_LO +: idxW];
		end
	end

	// write lands in the last data-phase cycle
	always_ff @(posedge HCLK) begin
		if (active && wrQ && lastCycle && hReady) begin
			mem[idxQ] <= hWData;
		end
	end

	assign hReadyOut = !active || lastCycle;
	assign hRData    = (active && !wrQ && lastCycle) ? mem[idxQ] : '0;
	assign hResp     = 1'b0;

endmodule

// File: hdl/ahbBusTop.sv
`include "ahbBus_config.svh"

module ahbBusTop (
	input  logic                     HCLK,
	input  logic                     HRESETn,

	input  logic                     hBusReqM1,
	input  logic                     hBusReqM2,
	input  ahbBusPkg::transKind      hTransM1,
	input  ahbBusPkg::transKind      hTransM2,
	input  logic                     hWriteM1,
	input  logic                     hWriteM2,
	input  logic [`AHB_SIZE_W-1:0]   hSizeM1,
	input  logic [`AHB_SIZE_W-1:0]   hSizeM2,
	input  logic [`AHB_BURST_W-1:0]  hBurstM1,
	input  logic [`AHB_BURST_W-1:0]  hBurstM2,
	input  logic [`AHB_PROT_W-1:0]   hProtM1,
	input  logic [`AHB_PROT_W-1:0]   hProtM2,
	input  logic [`AHB_ADDR_W-1:0]   hAddrM1,
	input  logic [`AHB_ADDR_W-1:0]   hAddrM2,
	input  logic [`AHB_DATA_W-1:0]   hWDataM1,
	input  logic [`AHB_DATA_W-1:0]   hWDataM2,

	output logic                     hGrantM1,
	output logic                     hGrantM2,
	output ahbBusPkg::masterId       hMaster,
	output logic                     hReady,
	output logic                     hResp,
	output logic [`AHB_DATA_W-1:0]   hRData
);

	// shared address and data phase bus
	ahbBusPkg::transKind      hTrans;
	logic                     hWrite;
	logic [`AHB_SIZE_W-1:0]   hSize;
	logic [`AHB_BURST_W-1:0]  hBurst;
	logic [`AHB_PROT_W-1:0]   hProt;
	logic [`AHB_ADDR_W-1:0]   hAddr;
	logic [`AHB_DATA_W-1:0]   hWData;

	// slave side
	logic                     hSel0;
	logic                     hSel1;
	ahbBusPkg::slaveSel       dataSel;
	logic [`AHB_DATA_W-1:0]   hRData0;
	logic [`AHB_DATA_W-1:0]   hRData1;
	logic                     hReadyOut0;
	logic                     hReadyOut1;
	logic                     hReadyOutDef;
	logic                     hResp0;
	logic                     hResp1;
	logic                     hRespDef;

	ahbArbiter arbiter0 (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.hBusReqM1 (hBusReqM1),
		.hBusReqM2 (hBusReqM2),
		.hReady    (hReady),
		.hGrantM1  (hGrantM1),
		.hGrantM2  (hGrantM2),
		.hMaster   (hMaster)
	);

	ahbMuxM2S muxM2S0 (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.hMaster  (hMaster),
		.hReady   (hReady),
		.hTransM1 (hTransM1),
		.hTransM2 (hTransM2),
		.hWriteM1 (hWriteM1),
		.hWriteM2 (hWriteM2),
		.hSizeM1  (hSizeM1),
		.hSizeM2  (hSizeM2),
		.hBurstM1 (hBurstM1),
		.hBurstM2 (hBurstM2),
		.hProtM1  (hProtM1),
		.hProtM2  (hProtM2),
		.hAddrM1  (hAddrM1),
		.hAddrM2  (hAddrM2),
		.hWDataM1 (hWDataM1),
		.hWDataM2 (hWDataM2),
		.hTrans   (hTrans),
		.hWrite   (hWrite),
		.hSize    (hSize),
		.hBurst   (hBurst),
		.hProt    (hProt),
		.hAddr    (hAddr),
		.hWData   (hWData)
	);

	ahbDecoder decoder0 (
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.hAddr        (hAddr),
		.hTrans       (hTrans),
		.hReady       (hReady),
		.hSel0        (hSel0),
		.hSel1        (hSel1),
		.dataSel      (dataSel),
		.hReadyOutDef (hReadyOutDef),
		.hRespDef     (hRespDef)
	);

	ahbMuxS2M muxS2M0 (
		.dataSel      (dataSel),
		.hRData0      (hRData0),
		.hRData1      (hRData1),
		.hReadyOut0   (hReadyOut0),
		.hReadyOut1   (hReadyOut1),
		.hReadyOutDef (hReadyOutDef),
		.hResp0       (hResp0),
		.hResp1       (hResp1),
		.hRespDef     (hRespDef),
		.hRData       (hRData),
		.hReady       (hReady),
		.hResp        (hResp)
	);

	ahbSramSlave #(.waitStates(`SRAM0_WAIT)) sram0 (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.hSel      (hSel0),
		.hTrans    (hTrans),
		.hWrite    (hWrite),
		.hSize     (hSize),
		.hAddr     (hAddr),
		.hWData    (hWData),
		.hReady    (hReady),
		.hRData    (hRData0),
		.hReadyOut (hReadyOut0),
		.hResp     (hResp0)
	);

	ahbSramSlave #(.waitStates(`SRAM1_WAIT)) sram1 (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.hSel      (hSel1),
		.hTrans    (hTrans),
		.hWrite    (hWrite),
		.hSize     (hSize),
		.hAddr     (hAddr),
		.hWData    (hWData),
		.hReady    (hReady),
		.hRData    (hRData1),
		.hReadyOut (hReadyOut1),
		.hResp     (hResp1)
	);

endmodule

// File: sim/ahbBusTb.sv
`include "ahbBus_config.svh"

module ahbBusTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int waitLimit = 200;
	localparam int wordCount = 8;

	logic                     HCLK;
	logic                     HRESETn;
	logic                     hBusReqM1;
	logic                     hBusReqM2;
	ahbBusPkg::transKind      hTransM1;
	ahbBusPkg::transKind      hTransM2;
	logic                     hWriteM1;
	logic                     hWriteM2;
	logic [`AHB_SIZE_W-1:0]   hSizeM1;
	logic [`AHB_SIZE_W-1:0]   hSizeM2;
	logic [`AHB_BURST_W-1:0]  hBurstM1;
	logic [`AHB_BURST_W-1:0]  hBurstM2;
	logic [`AHB_PROT_W-1:0]   hProtM1;
	logic [`AHB_PROT_W-1:0]   hProtM2;
	logic [`AHB_ADDR_W-1:0]   hAddrM1;
	logic [`AHB_ADDR_W-1:0]   hAddrM2;
	logic [`AHB_DATA_W-1:0]   hWDataM1;
	logic [`AHB_DATA_W-1:0]   hWDataM2;
	logic                     hGrantM1;
	logic                     hGrantM2;
	ahbBusPkg::masterId       hMaster;
	logic                     hReady;
	logic                     hResp;
	logic [`AHB_DATA_W-1:0]   hRData;

	logic [31:0]              refMem [logic [31:0]];
	int                       seed;
	ahbBusPkg::masterId       prevMaster;
	logic                     prevReady;

	ahbBusTop dut0 (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.hBusReqM1 (hBusReqM1),
		.hBusReqM2 (hBusReqM2),
		.hTransM1  (hTransM1),
		.hTransM2  (hTransM2),
		.hWriteM1  (hWriteM1),
		.hWriteM2  (hWriteM2),
		.hSizeM1   (hSizeM1),
		.hSizeM2   (hSizeM2),
		.hBurstM1  (hBurstM1),
		.hBurstM2  (hBurstM2),
		.hProtM1   (hProtM1),
		.hProtM2   (hProtM2),
		.hAddrM1   (hAddrM1),
		.hAddrM2   (hAddrM2),
		.hWDataM1  (hWDataM1),
		.hWDataM2  (hWDataM2),
		.hGrantM1  (hGrantM1),
		.hGrantM2  (hGrantM2),
		.hMaster   (hMaster),
		.hReady    (hReady),
		.hResp     (hResp),
		.hRData    (hRData)
	);

	always #5 HCLK = ~HCLK;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic failNow(input string msg);
		$display("%s at %0t", msg, $time);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped on error");
	endtask

	task automatic checkEqual(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// ownership may only move on an edge that completes a transfer
	always @(negedge HCLK) begin
		if (HRESETn) begin
			if (hMaster != prevMaster && !prevReady) begin
				failNow("hMaster changed on an edge where hReady was low");
			end
			prevMaster = hMaster;
			prevReady  = hReady;
		end
	end

	function automatic ahbBusPkg::masterId masterOf(input int m);
		return (m == 1) ? ahbBusPkg::master1 : ahbBusPkg::master2;
	endfunction

	function automatic int expectedWaits(input logic [31:0] addr);
		return (addr[31:28] == `SLAVE1_BASE) ? `SRAM1_WAIT : `SRAM0_WAIT;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// master bus models
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic setReq(input int m, input logic value);
		if (m == 1) begin
			hBusReqM1 <= value;
		end else begin
			hBusReqM2 <= value;
		end
	endtask

	task automatic driveMaster(input int m, input ahbBusPkg::transKind trans, input logic wr,
			input logic [31:0] addr, input logic [31:0] wdata);
		if (m == 1) begin
			hTransM1 <= trans;
			hWriteM1 <= wr;
			hAddrM1  <= addr;
			hWDataM1 <= wdata;
		end else begin
			hTransM2 <= trans;
			hWriteM2 <= wr;
			hAddrM2  <= addr;
			hWDataM2 <= wdata;
		end
	endtask

	task automatic waitAnyGrant(output int m);
		int n;
		n = 0;
		forever begin
			@(negedge HCLK);
			if (hGrantM1 || hGrantM2) break;
			n = n + 1;
			if (n > waitLimit) failNow("timeout waiting for a bus grant");
		end
		m = hGrantM1 ? 1 : 2;
	endtask

	task automatic waitMaster(input ahbBusPkg::masterId id);
		int n;
		n = 0;
		forever begin
			@(negedge HCLK);
			if (hMaster == id) break;
			n = n + 1;
			if (n > waitLimit) failNow("timeout waiting for hMaster to reach the expected owner");
		end
	endtask

	task automatic requestBus(input int m);
		int g;
		@(posedge HCLK);
		setReq(m, 1'b1);
		waitAnyGrant(g);
		checkEqual("granted master", m, g);
		waitMaster(masterOf(m));
	endtask

	task automatic releaseBus(input int m);
		@(posedge HCLK);
		setReq(m, 1'b0);
	endtask

	// one NONSEQ beat; returns at the negedge before the completing edge
	task automatic transfer(input int m, input logic wr, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic resp,
			output int lowCnt, output logic waitResp);
		int n;
		n = 0;
		lowCnt = 0;
		waitResp = 1'b0;
		@(posedge HCLK);
		driveMaster(m, ahbBusPkg::transNonSeq, wr, addr, wdata);
		forever begin
			@(negedge HCLK);
			if (hReady) break;
			n = n + 1;
			if (n > waitLimit) failNow("timeout waiting for hReady in the address phase");
		end
		@(posedge HCLK);
		driveMaster(m, ahbBusPkg::transIdle, 1'b0, addr, wdata);
		forever begin
			@(negedge HCLK);
			if (hReady) break;
			lowCnt = lowCnt + 1;
			waitResp = waitResp | hResp;
			if (lowCnt > waitLimit) failNow("timeout waiting for hReady in the data phase");
		end
		rdata = hRData;
		resp = hResp;
	endtask

	task automatic singleWrite(input int m, input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        resp;
		logic        waitResp;
		int          lowCnt;
		transfer(m, 1'b1, addr, data, rdata, resp, lowCnt, waitResp);
		checkEqual("hResp on write", 1'b0, resp);
		checkEqual("hReady low cycles on write", expectedWaits(addr), lowCnt);
		refMem[addr] = data;
	endtask

	task automatic singleRead(input int m, input logic [31:0] addr);
		logic [31:0] rdata;
		logic        resp;
		logic        waitResp;
		int          lowCnt;
		if (!refMem.exists(addr)) failNow("read from an address the test never wrote");
		transfer(m, 1'b0, addr, '0, rdata, resp, lowCnt, waitResp);
		checkEqual("hResp on read", 1'b0, resp);
		checkEqual("hReady low cycles on read", expectedWaits(addr), lowCnt);
		checkEqual("hRData", refMem[addr], rdata);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic testReset();
		@(negedge HCLK);
		checkEqual("hGrantM1", 1'b0, hGrantM1);
		checkEqual("hGrantM2", 1'b0, hGrantM2);
		checkEqual("hMaster", ahbBusPkg::masterNone, hMaster);
		checkEqual("hReady", 1'b1, hReady);
		checkEqual("hResp", 1'b0, hResp);
	endtask

	// master m fills wordCount words from base, then reads them back
	task automatic testSram(input int m, input logic [31:0] base);
		int i;
		requestBus(m);
		for (i = 0; i < wordCount; i++) begin
			singleWrite(m, base + i * 4, $random(seed));
		end
		for (i = 0; i < wordCount; i++) begin
			singleRead(m, base + i * 4);
		end
		releaseBus(m);
		waitMaster(ahbBusPkg::masterNone);
	endtask

	task automatic testArbitration();
		int          i;
		int          owner;
		int          g;
		logic [31:0] addr;
		@(posedge HCLK);
		hBusReqM1 <= 1'b1;
		hBusReqM2 <= 1'b1;
		// master 2 counts as last owner after reset
		owner = 1;
		for (i = 0; i < wordCount; i++) begin
			waitAnyGrant(g);
			checkEqual("granted master", owner, g);
			waitMaster(masterOf(owner));
			addr = (owner == 1) ? 32'h0000_0040 : 32'h1000_0040;
			singleWrite(owner, addr + i * 4, $random(seed));
			releaseBus(owner);
			@(posedge HCLK);
			setReq(owner, 1'b1);
			owner = 3 - owner;
		end
		@(posedge HCLK);
		hBusReqM1 <= 1'b0;
		hBusReqM2 <= 1'b0;
		waitMaster(ahbBusPkg::masterNone);
		requestBus(1);
		for (i = 0; i < wordCount; i++) begin
			if (refMem.exists(32'h0000_0040 + i * 4)) singleRead(1, 32'h0000_0040 + i * 4);
			if (refMem.exists(32'h1000_0040 + i * 4)) singleRead(1, 32'h1000_0040 + i * 4);
		end
		releaseBus(1);
		waitMaster(ahbBusPkg::masterNone);
	endtask

	task automatic testUnmapped();
		logic [31:0] rdata;
		logic        resp;
		logic        waitResp;
		int          lowCnt;
		requestBus(1);
		transfer(1, 1'b0, 32'h3000_0000, '0, rdata, resp, lowCnt, waitResp);
		checkEqual("hReady low cycles on error", 1, lowCnt);
		checkEqual("hResp in first error cycle", 1'b1, waitResp);
		checkEqual("hResp in second error cycle", 1'b1, resp);
		singleRead(1, 32'h0000_0000);
		releaseBus(1);
		waitMaster(ahbBusPkg::masterNone);
	endtask

	// masters drive writes while the default master owns the bus
	task automatic testDefaultMaster();
		int i;
		@(posedge HCLK);
		driveMaster(1, ahbBusPkg::transNonSeq, 1'b1, 32'h0000_0000, $random(seed));
		driveMaster(2, ahbBusPkg::transNonSeq, 1'b1, 32'h1000_0000, $random(seed));
		repeat (4) begin
			@(negedge HCLK);
			checkEqual("hMaster", ahbBusPkg::masterNone, hMaster);
			checkEqual("hGrantM1", 1'b0, hGrantM1);
			checkEqual("hGrantM2", 1'b0, hGrantM2);
		end
		@(posedge HCLK);
		driveMaster(1, ahbBusPkg::transIdle, 1'b0, '0, '0);
		driveMaster(2, ahbBusPkg::transIdle, 1'b0, '0, '0);
		requestBus(2);
		for (i = 0; i < wordCount; i++) begin
			singleRead(2, 32'h0000_0000 + i * 4);
			singleRead(2, 32'h1000_0000 + i * 4);
		end
		releaseBus(2);
		waitMaster(ahbBusPkg::masterNone);
	endtask

	initial begin
		HCLK       = 1'b0;
		HRESETn    = 1'b0;
		hBusReqM1  = 1'b0;
		hBusReqM2  = 1'b0;
		hTransM1   = ahbBusPkg::transIdle;
		hTransM2   = ahbBusPkg::transIdle;
		hWriteM1   = 1'b0;
		hWriteM2   = 1'b0;
		// word transfers, single beats
		hSizeM1    = 3'b010;
		hSizeM2    = 3'b010;
		hBurstM1   = '0;
		hBurstM2   = '0;
		hProtM1    = 4'b0011;
		hProtM2    = 4'b0011;
		hAddrM1    = '0;
		hAddrM2    = '0;
		hWDataM1   = '0;
		hWDataM2   = '0;
		seed       = 32'h5c0c;
		prevMaster = ahbBusPkg::masterNone;
		prevReady  = 1'b1;
		repeat (8) @(posedge HCLK);
		HRESETn <= 1'b1;
		testReset();
		testSram(1, 32'h0000_0000);
		testSram(2, 32'h1000_0000);
		testArbitration();
		testUnmapped();
		testDefaultMaster();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: src.f
+incdir+hdl
hdl/ahbBusPkg.sv
hdl/ahbArbiter.sv
hdl/ahbMuxM2S.sv
hdl/ahbDecoder.sv
hdl/ahbMuxS2M.sv
hdl/ahbSramSlave.sv
hdl/ahbBusTop.sv
sim/ahbBusTb.sv

// File: Makefile
# Verilator build and run of the AHB bus testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary -Wno-fatal --top-module ahbBusTb -f src.f --Mdir obj_dir -o ahbBusSim
	./obj_dir/ahbBusSim

clean:
	rm -rf obj_dir
